/* rv_config.svh */
/*
 * Global width and reset settings for the RV32I decode/execute slice.
 * Include this file wherever XLEN or the fetch start address is needed.
 */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width, 64 also supported by the RTL
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* rv_isa_pkg.sv */
/*
 * RISC-V base ISA encodings used by the decoder, the execute stage and
 * the testbench reference model.
 */
package rv_isa_pkg;

  // Major opcodes of the supported instruction groups
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011
  } opcode_t;

  // Low three bits follow funct3, bit 3 is the funct7[5] alternate
  typedef enum logic [3:0] {
    ADD    = 4'b0000,
    SLL    = 4'b0001,
    SLT    = 4'b0010,
    SLTU   = 4'b0011,
    XOR    = 4'b0100,
    SRL    = 4'b0101,
    OR     = 4'b0110,
    AND    = 4'b0111,
    SUB    = 4'b1000,
    SRA    = 4'b1101,
    PASS_B = 4'b1111    // LUI
  } alu_op_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_funct3_t;

endpackage

/* rv_pipe_pkg.sv */
/*
 * Pipeline-internal control encodings shared by the decode and execute
 * stages and by the testbench reference decode.
 */
package rv_pipe_pkg;

  // Source of the value written back to rd
  typedef enum logic [1:0] {
    WB_ALU = 2'b00,
    WB_PC4 = 2'b01    // Link address for JAL and JALR
  } wb_sel_t;

  // Immediate layouts of the base ISA
  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_fmt_t;

endpackage

/* rv_decoder.sv */
/*
 * Instruction decode stage. Splits the fetched word into register
 * addresses, a sign-extended immediate and the control word for ID/EX.
 */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_decoder #(
  parameter int XLEN = `XLEN
) (
  input  logic [31:0]            instr,
  input  logic [XLEN-1:0]        instr_pc,
  input  logic                   instr_valid,
  input  logic [XLEN-1:0]        rs1_rdata,
  input  logic [XLEN-1:0]        rs2_rdata,
  output logic [4:0]             rs1_addr,
  output logic [4:0]             rs2_addr,
  output logic [4:0]             rd_addr,
  output logic [XLEN-1:0]        rs1_data,
  output logic [XLEN-1:0]        rs2_data,
  output logic [XLEN-1:0]        imm,
  output rv_isa_pkg::alu_op_t    alu_op,
  output logic                   alu_src,     // 1 selects imm as operand B
  output logic                   branch,
  output logic                   jump,
  output logic                   jalr,
  output logic                   reg_write,
  output rv_pipe_pkg::wb_sel_t   wb_sel,
  output logic                   illegal,
  output logic                   valid,
  output logic [XLEN-1:0]        pc
);

  rv_isa_pkg::opcode_t   opcode;
  rv_pipe_pkg::imm_fmt_t imm_fmt;
  logic [2:0]            funct3;
  logic                  alt_op;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  writes_rd;
  logic                  known;

  assign opcode = rv_isa_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign alt_op = instr[30];

  // Unused source fields read as x0 so no false forwarding match occurs
  assign rs1_addr = uses_rs1 ? instr[19:15] : 5'd0;
  assign rs2_addr = uses_rs2 ? instr[24:20] : 5'd0;
  assign rd_addr  = instr[11:7];
  assign rs1_data = rs1_rdata;
  assign rs2_data = rs2_rdata;
  assign pc       = instr_pc;
  assign valid    = instr_valid;

  assign illegal   = instr_valid && !known;
  assign reg_write = instr_valid && writes_rd && (rd_addr != 5'd0);  // x0 writes dropped

  always_comb begin
    known     = 1'b1;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    writes_rd = 1'b0;
    alu_op    = rv_isa_pkg::ADD;
    alu_src   = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    jalr      = 1'b0;
    wb_sel    = rv_pipe_pkg::WB_ALU;
    imm_fmt   = rv_pipe_pkg::IMM_I;
    case (opcode)
      rv_isa_pkg::OP: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        writes_rd = 1'b1;
        // funct7[5] only matters for SUB and SRA
        alu_op = rv_isa_pkg::alu_op_t'({alt_op && (funct3 == 3'b000 || funct3 == 3'b101),
                                        funct3});
      end
      rv_isa_pkg::OP_IMM: begin
        uses_rs1  = 1'b1;
        writes_rd = 1'b1;
        alu_src   = 1'b1;
        alu_op    = rv_isa_pkg::alu_op_t'({alt_op && (funct3 == 3'b101), funct3});  // SRAI
      end
      rv_isa_pkg::LUI: begin
        writes_rd = 1'b1;
        alu_src   = 1'b1;
        alu_op    = rv_isa_pkg::PASS_B;
        imm_fmt   = rv_pipe_pkg::IMM_U;
      end
      rv_isa_pkg::AUIPC: begin
        writes_rd = 1'b1;
        alu_src   = 1'b1;       // PC on operand A in execute
        imm_fmt   = rv_pipe_pkg::IMM_U;
      end
      rv_isa_pkg::JAL: begin
        writes_rd = 1'b1;
        jump      = 1'b1;
        wb_sel    = rv_pipe_pkg::WB_PC4;
        imm_fmt   = rv_pipe_pkg::IMM_J;
      end
      rv_isa_pkg::JALR: begin
        uses_rs1  = 1'b1;
        writes_rd = 1'b1;
        jump      = 1'b1;
        jalr      = 1'b1;
        wb_sel    = rv_pipe_pkg::WB_PC4;
      end
      rv_isa_pkg::BRANCH: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        branch   = 1'b1;
        imm_fmt  = rv_pipe_pkg::IMM_B;
      end
      default: known = 1'b0;
    endcase
  end

  // Sign extension through the signed size cast
  always_comb begin
    case (imm_fmt)
      rv_pipe_pkg::IMM_S: imm = XLEN'($signed({instr[31:25], instr[11:7]}));
      rv_pipe_pkg::IMM_B: imm = XLEN'($signed({instr[31], instr[7], instr[30:25],
                                                instr[11:8], 1'b0}));
      rv_pipe_pkg::IMM_U: imm = XLEN'($signed({instr[31:12], 12'b0}));
      rv_pipe_pkg::IMM_J: imm = XLEN'($signed({instr[31], instr[19:12], instr[20],
                                                instr[30:21], 1'b0}));
      default:            imm = XLEN'($signed(instr[31:20]));
    endcase
  end

endmodule

/* rv_regfile.sv */
/*
 * Integer register file, 32 entries, two combinational read ports and one
 * write port. Same-cycle writes are bypassed to the read ports.
 */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_regfile #(
  parameter int XLEN = `XLEN
) (
  input  logic            clk,
  input  logic            reset_n,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  input  logic            we,
  input  logic [4:0]      rd_addr,
  input  logic [XLEN-1:0] rd_wdata,
  output logic [XLEN-1:0] rs1_rdata,
  output logic [XLEN-1:0] rs2_rdata
);

  logic [XLEN-1:0] regs [0:31];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != 5'd0) begin   // x0 never written
      regs[rd_addr] <= rd_wdata;
    end
  end

  always_comb begin
    if (rs1_addr == 5'd0)
      rs1_rdata = '0;
    else if (we && rs1_addr == rd_addr)
      rs1_rdata = rd_wdata;     // Write-through
    else
      rs1_rdata = regs[rs1_addr];
  end

  always_comb begin
    if (rs2_addr == 5'd0)
      rs2_rdata = '0;
    else if (we && rs2_addr == rd_addr)
      rs2_rdata = rd_wdata;     // Write-through
    else
      rs2_rdata = regs[rs2_addr];
  end

endmodule

/* idex_register.sv */
/*
 * ID/EX pipeline register. Latches the decoded control word every cycle;
 * a flush turns the incoming instruction into a bubble.
 */
`timescale 1ns/100ps
`include "rv_config.svh"

module idex_register #(
  parameter int XLEN = `XLEN
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 flush,          // Wrong-path kill from execute
  input  logic [XLEN-1:0]      pc,
  input  logic [XLEN-1:0]      rs1_data,
  input  logic [XLEN-1:0]      rs2_data,
  input  logic [4:0]           rs1_addr,
  input  logic [4:0]           rs2_addr,
  input  logic [4:0]           rd_addr,
  input  logic [XLEN-1:0]      imm,
  input  rv_isa_pkg::alu_op_t  alu_op,
  input  logic                 alu_src,
  input  logic                 branch,
  input  logic                 jump,
  input  logic                 jalr,
  input  logic                 reg_write,
  input  rv_pipe_pkg::wb_sel_t wb_sel,
  input  logic                 valid,
  input  logic                 illegal,
  input  logic [31:0]          instruction,
  output logic [XLEN-1:0]      pc_out,
  output logic [XLEN-1:0]      rs1_data_out,
  output logic [XLEN-1:0]      rs2_data_out,
  output logic [4:0]           rs1_addr_out,
  output logic [4:0]           rs2_addr_out,
  output logic [4:0]           rd_addr_out,
  output logic [XLEN-1:0]      imm_out,
  output rv_isa_pkg::alu_op_t  alu_op_out,
  output logic                 alu_src_out,
  output logic                 branch_out,
  output logic                 jump_out,
  output logic                 jalr_out,
  output logic                 reg_write_out,
  output rv_pipe_pkg::wb_sel_t wb_sel_out,
  output logic                 valid_out,
  output logic                 illegal_out,
  output logic [31:0]          instruction_out
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc_out          <= '0;
      rs1_data_out    <= '0;
      rs2_data_out    <= '0;
      rs1_addr_out    <= 5'd0;
      rs2_addr_out    <= 5'd0;
      rd_addr_out     <= 5'd0;
      imm_out         <= '0;
      alu_op_out      <= rv_isa_pkg::ADD;
      alu_src_out     <= 1'b0;
      branch_out      <= 1'b0;
      jump_out        <= 1'b0;
      jalr_out        <= 1'b0;
      reg_write_out   <= 1'b0;
      wb_sel_out      <= rv_pipe_pkg::WB_ALU;
      valid_out       <= 1'b0;
      illegal_out     <= 1'b0;
      instruction_out <= 32'd0;
    end else begin
      pc_out       <= pc;           // Data kept through a flush
      rs1_data_out <= rs1_data;
      rs2_data_out <= rs2_data;
      if (flush) begin
        rs1_addr_out    <= 5'd0;
        rs2_addr_out    <= 5'd0;
        rd_addr_out     <= 5'd0;
        imm_out         <= '0;
        alu_op_out      <= rv_isa_pkg::ADD;
        alu_src_out     <= 1'b0;
        branch_out      <= 1'b0;
        jump_out        <= 1'b0;
        jalr_out        <= 1'b0;
        reg_write_out   <= 1'b0;    // Bubble retires nothing
        wb_sel_out      <= rv_pipe_pkg::WB_ALU;
        valid_out       <= 1'b0;
        illegal_out     <= 1'b0;    // No trap from a wrong-path word
        instruction_out <= 32'd0;
      end else begin
        rs1_addr_out    <= rs1_addr;
        rs2_addr_out    <= rs2_addr;
        rd_addr_out     <= rd_addr;
        imm_out         <= imm;
        alu_op_out      <= alu_op;
        alu_src_out     <= alu_src;
        branch_out      <= branch;
        jump_out        <= jump;
        jalr_out        <= jalr;
        reg_write_out   <= reg_write;
        wb_sel_out      <= wb_sel;
        valid_out       <= valid;
        illegal_out     <= illegal;
        instruction_out <= instruction;
      end
    end
  end

endmodule

/* rv_execute.sv */
/*
 * Execute stage. Forwards from the EX/WB register, runs the ALU and the
 * branch compare, raises redirects and traps, and holds the result for
 * write-back into the register file.
 */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_execute #(
  parameter int XLEN = `XLEN
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [XLEN-1:0]      pc,
  input  logic [XLEN-1:0]      rs1_data,
  input  logic [XLEN-1:0]      rs2_data,
  input  logic [4:0]           rs1_addr,
  input  logic [4:0]           rs2_addr,
  input  logic [4:0]           rd_addr,
  input  logic [XLEN-1:0]      imm,
  input  rv_isa_pkg::alu_op_t  alu_op,
  input  logic                 alu_src,
  input  logic                 branch,
  input  logic                 jump,
  input  logic                 jalr,
  input  logic                 reg_write,
  input  rv_pipe_pkg::wb_sel_t wb_sel,
  input  logic                 valid,
  input  logic                 illegal,
  input  logic [31:0]          instruction,
  output logic                 flush,
  output logic                 redirect_valid,
  output logic [XLEN-1:0]      redirect_pc,
  output logic                 trap_valid,
  output logic [XLEN-1:0]      trap_pc,
  output logic                 wb_valid,
  output logic [4:0]           wb_rd,
  output logic [XLEN-1:0]      wb_data
);

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_y;
  logic [XLEN-1:0] jalr_sum;
  logic [SHW-1:0]  shamt;
  logic            cond;

  // EX/WB forwarding for the directly preceding instruction
  assign rs1_val = (wb_valid && wb_rd != 5'd0 && wb_rd == rs1_addr) ? wb_data : rs1_data;
  assign rs2_val = (wb_valid && wb_rd != 5'd0 && wb_rd == rs2_addr) ? wb_data : rs2_data;

  assign alu_a = (instruction[6:0] == rv_isa_pkg::AUIPC) ? pc : rs1_val;
  assign alu_b = alu_src ? imm : rs2_val;
  assign shamt = alu_b[SHW-1:0];

  always_comb begin
    case (alu_op)
      rv_isa_pkg::SUB:  alu_y = alu_a - alu_b;
      rv_isa_pkg::SLL:  alu_y = alu_a << shamt;
      rv_isa_pkg::SLT:  alu_y = XLEN'($signed(alu_a) < $signed(alu_b));
      rv_isa_pkg::SLTU: alu_y = XLEN'(alu_a < alu_b);
      rv_isa_pkg::XOR:  alu_y = alu_a ^ alu_b;
      rv_isa_pkg::SRL:  alu_y = alu_a >> shamt;
      rv_isa_pkg::SRA:  alu_y = $signed(alu_a) >>> shamt;
      rv_isa_pkg::OR:   alu_y = alu_a | alu_b;
      rv_isa_pkg::AND:  alu_y = alu_a & alu_b;
      rv_isa_pkg::PASS_B: alu_y = alu_b;
      default:          alu_y = alu_a + alu_b;
    endcase
  end

  always_comb begin
    case (rv_isa_pkg::br_funct3_t'(instruction[14:12]))
      rv_isa_pkg::BEQ:  cond = (rs1_val == rs2_val);
      rv_isa_pkg::BNE:  cond = (rs1_val != rs2_val);
      rv_isa_pkg::BLT:  cond = ($signed(rs1_val) < $signed(rs2_val));
      rv_isa_pkg::BGE:  cond = ($signed(rs1_val) >= $signed(rs2_val));
      rv_isa_pkg::BLTU: cond = (rs1_val < rs2_val);
      rv_isa_pkg::BGEU: cond = (rs1_val >= rs2_val);
      default:          cond = 1'b0;
    endcase
  end

  assign jalr_sum       = rs1_val + imm;
  assign redirect_valid = valid && !illegal && (jump || (branch && cond));
  assign redirect_pc    = jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;
  assign flush          = redirect_valid;     // Kill the wrong-path fetch

  assign trap_valid = valid && illegal;
  assign trap_pc    = pc;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wb_valid <= 1'b0;
      wb_rd    <= 5'd0;
    end else begin
      wb_valid <= valid && reg_write && !illegal;
      wb_rd    <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    wb_data <= (wb_sel == rv_pipe_pkg::WB_PC4) ? pc + XLEN'(4) : alu_y;  // Link or ALU
  end

endmodule

/* rv_id_ex_core.sv */
/*
 * Decode/execute slice top level. Connects decoder, register file, ID/EX
 * register and execute stage; the fetch side is driven externally.
 */
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_id_ex_core #(
  parameter int XLEN = `XLEN
) (
  input  logic            clk,
  input  logic            reset_n,
  input  logic [31:0]     instr,
  input  logic [XLEN-1:0] instr_pc,
  input  logic            instr_valid,
  output logic            wb_valid,
  output logic [4:0]      wb_rd,
  output logic [XLEN-1:0] wb_data,
  output logic            redirect_valid,
  output logic [XLEN-1:0] redirect_pc,
  output logic            trap_valid,
  output logic [XLEN-1:0] trap_pc
);

  // Decode side of ID/EX
  logic [XLEN-1:0]      pc, rs1_data, rs2_data, imm, rs1_rdata, rs2_rdata;
  logic [4:0]           rs1_addr, rs2_addr, rd_addr;
  rv_isa_pkg::alu_op_t  alu_op;
  rv_pipe_pkg::wb_sel_t wb_sel;
  logic                 alu_src, branch, jump, jalr, reg_write, valid, illegal;

  // Execute side of ID/EX
  logic [XLEN-1:0]      pc_out, rs1_data_out, rs2_data_out, imm_out;
  logic [4:0]           rs1_addr_out, rs2_addr_out, rd_addr_out;
  rv_isa_pkg::alu_op_t  alu_op_out;
  rv_pipe_pkg::wb_sel_t wb_sel_out;
  logic                 alu_src_out, branch_out, jump_out, jalr_out;
  logic                 reg_write_out, valid_out, illegal_out;
  logic [31:0]          instruction_out;
  logic                 flush;

  rv_decoder #(.XLEN(XLEN)) rv_decoder_inst (.*);

  rv_regfile #(.XLEN(XLEN)) rv_regfile_inst (
    .clk,
    .reset_n,
    .rs1_addr,
    .rs2_addr,
    .we        (wb_valid),
    .rd_addr   (wb_rd),
    .rd_wdata  (wb_data),
    .rs1_rdata,
    .rs2_rdata
  );

  rv_execute #(.XLEN(XLEN)) rv_execute_inst (
    .clk,
    .reset_n,
    .pc          (pc_out),
    .rs1_data    (rs1_data_out),
    .rs2_data    (rs2_data_out),
    .rs1_addr    (rs1_addr_out),
    .rs2_addr    (rs2_addr_out),
    .rd_addr     (rd_addr_out),
    .imm         (imm_out),
    .alu_op      (alu_op_out),
    .alu_src     (alu_src_out),
    .branch      (branch_out),
    .jump        (jump_out),
    .jalr        (jalr_out),
    .reg_write   (reg_write_out),
    .wb_sel      (wb_sel_out),
    .valid       (valid_out),
    .illegal     (illegal_out),
    .instruction (instruction_out),
    .flush,
    .redirect_valid,
    .redirect_pc,
    .trap_valid,
    .trap_pc,
    .wb_valid,
    .wb_rd,
    .wb_data
  );

  // Remaining ports match the wire names above
  idex_register #(.XLEN(XLEN)) idex_register_inst (
    .instruction (instr),
    .*
  );

endmodule

/* rv_id_ex_properties.sv */
/*
 * Assertions on the ID/EX register, bound into every idex_register.
 * Covers the flush bubble, write/valid consistency and reset state.
 */
`timescale 1ns/100ps

module rv_id_ex_properties (
  input logic clk,
  input logic reset_n,
  input logic flush,
  input logic valid_out,
  input logic reg_write_out,
  input logic branch_out,
  input logic jump_out,
  input logic jalr_out,
  input logic alu_src_out,
  input logic illegal_out
);

  // Flushed slot must come out as a bubble
  flush_bubble: assert property (@(posedge clk) disable iff (!reset_n)
    flush |=> (!valid_out && !reg_write_out))
    else $error("flush did not produce a bubble");

  write_needs_valid: assert property (@(posedge clk) disable iff (!reset_n)
    reg_write_out |-> valid_out)
    else $error("reg_write_out set without valid_out");

  reset_clears_control: assert property (@(posedge clk)
    !reset_n |-> !(valid_out || reg_write_out || branch_out || jump_out ||
                   jalr_out || alu_src_out || illegal_out))
    else $error("control bits not cleared in reset");

endmodule

bind idex_register rv_id_ex_properties rv_id_ex_properties_inst (.*);

/* tb_rv_id_ex_core.sv */
/*
 * Self-checking testbench for the decode/execute slice. Acts as the fetch
 * stage, runs a reference ISS over the same program image and compares
 * register writes, redirects and traps.
 */
`timescale 1ns/100ps
`include "rv_config.svh"

module tb_rv_id_ex_core;

  localparam int XLEN = `XLEN;

  logic            clk = 1'b0;
  logic            reset_n;
  logic [31:0]     instr;
  logic [XLEN-1:0] instr_pc;
  logic            instr_valid;
  logic            wb_valid;
  logic [4:0]      wb_rd;
  logic [XLEN-1:0] wb_data;
  logic            redirect_valid;
  logic [XLEN-1:0] redirect_pc;
  logic            trap_valid;
  logic [XLEN-1:0] trap_pc;

  logic [31:0]     prog [0:255];
  int              prog_len = 0;
  logic [31:0]     rng = 32'hf289;
  logic [XLEN-1:0] iss_regs [0:31];
  logic [XLEN-1:0] fetch_pc;
  logic            fetch_done = 1'b0;
  int              cycles = 0;
  int              cycle_limit;
  int              mismatch_count = 0;
  int              other_count = 0;

  // Expected events from the reference run
  logic [4:0]      exp_rd [$];
  logic [XLEN-1:0] exp_data [$];
  logic [XLEN-1:0] exp_redirect [$];
  logic [XLEN-1:0] exp_trap [$];

  rv_id_ex_core rv_id_ex_core_inst (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::JAL};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // Random value through LUI then a dependent ADDI
  task automatic load_random(input logic [4:0] rd);
    rng = xorshift32(rng);
    emit({rng[31:12], rd, rv_isa_pkg::LUI});
    emit(enc_i(rng[11:0], rd, 3'b000, rd, rv_isa_pkg::OP_IMM));
  endtask

  task automatic build_program();
    logic [2:0] br_codes [0:5];
    logic [4:0] pair_a [0:2];
    logic [4:0] pair_b [0:2];
    br_codes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    pair_a = '{5'd1, 5'd2, 5'd1};
    pair_b = '{5'd2, 5'd1, 5'd1};
    for (int r = 1; r <= 6; r++) load_random(5'(r));
    for (int f = 0; f < 8; f++) begin     // All R-type ops, SUB and SRA included
      emit(enc_r(7'b0, 5'd3, 5'd1, 3'(f), 5'(10 + f)));
      if (f == 0 || f == 5)
        emit(enc_r(7'b0100000, 5'd3, 5'd4, 3'(f), 5'(18 + f)));
    end
    for (int f = 0; f < 8; f++) begin
      rng = xorshift32(rng);
      if (f == 1 || f == 5) begin
        emit(enc_i({7'b0, rng[4:0]}, 5'd5, 3'(f), 5'(10 + f), rv_isa_pkg::OP_IMM));
        if (f == 5)
          emit(enc_i({7'b0100000, rng[9:5]}, 5'd6, 3'(f), 5'd9, rv_isa_pkg::OP_IMM));
      end else begin
        emit(enc_i(rng[11:0], 5'd5, 3'(f), 5'(10 + f), rv_isa_pkg::OP_IMM));
      end
    end
    // Dependent chain at distance 1 and 2
    emit(enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd20));
    emit(enc_r(7'b0100000, 5'd3, 5'd20, 3'b000, 5'd21));
    emit(enc_r(7'b0, 5'd21, 5'd20, 3'b100, 5'd22));
    emit(enc_r(7'b0, 5'd20, 5'd22, 3'b110, 5'd23));
    emit(enc_i(12'h7ff, 5'd23, 3'b000, 5'd23, rv_isa_pkg::OP_IMM));
    // x0 stays zero
    emit(enc_i(12'd5, 5'd1, 3'b000, 5'd0, rv_isa_pkg::OP_IMM));
    emit({20'habcde, 5'd0, rv_isa_pkg::LUI});
    emit(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd24));
    emit({20'h12345, 5'd24, rv_isa_pkg::LUI});
    emit({20'h00fed, 5'd8, rv_isa_pkg::AUIPC});
    // Each condition on three operand pairs, wrong path at +4
    for (int b = 0; b < 6; b++) begin
      for (int p = 0; p < 3; p++) begin
        emit(enc_b(13'd8, pair_b[p], pair_a[p], br_codes[b]));
        emit(enc_i(12'd1, 5'd25, 3'b000, 5'd25, rv_isa_pkg::OP_IMM));
      end
    end
    emit(enc_j(21'd8, 5'd27));
    emit(enc_i(12'd1, 5'd25, 3'b000, 5'd25, rv_isa_pkg::OP_IMM));
    emit({20'd0, 5'd28, rv_isa_pkg::AUIPC});
    emit(enc_i(12'd13, 5'd28, 3'b000, 5'd29, rv_isa_pkg::JALR));  // Odd target
    emit(enc_i(12'd1, 5'd25, 3'b000, 5'd25, rv_isa_pkg::OP_IMM));
    emit(enc_i(12'd0, 5'd1, 3'b010, 5'd26, 7'b0000011));   // Unsupported opcode with a live rd
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd30, rv_isa_pkg::OP_IMM));
    emit(enc_r(7'b0, 5'd11, 5'd10, 3'b000, 5'd31));
  endtask

  function automatic logic [XLEN-1:0] imm_value(input logic [31:0] w,
                                                input rv_pipe_pkg::imm_fmt_t fmt);
    case (fmt)
      rv_pipe_pkg::IMM_S: return XLEN'($signed({w[31:25], w[11:7]}));
      rv_pipe_pkg::IMM_B: return XLEN'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      rv_pipe_pkg::IMM_U: return XLEN'($signed({w[31:12], 12'h000}));
      rv_pipe_pkg::IMM_J: return XLEN'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      default:            return XLEN'($signed(w[31:20]));
    endcase
  endfunction

  // Architectural step of one instruction
  function automatic void iss_step(input logic [31:0] w, input logic [XLEN-1:0] pc,
                                   output logic [XLEN-1:0] next_pc, output logic wr,
                                   output logic [4:0] rd, output logic [XLEN-1:0] val,
                                   output logic redir, output logic trap);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [2:0]      f3;
    logic            taken;
    a = iss_regs[w[19:15]];
    b = iss_regs[w[24:20]];
    f3 = w[14:12];
    rd = w[11:7];
    next_pc = pc + 4;
    wr = 1'b0;
    val = '0;
    redir = 1'b0;
    trap = 1'b0;
    case (w[6:0])
      rv_isa_pkg::OP, rv_isa_pkg::OP_IMM: begin
        wr = 1'b1;
        if (w[6:0] == rv_isa_pkg::OP_IMM)
          b = imm_value(w, rv_pipe_pkg::IMM_I);
        case (f3)
          3'b000: val = (w[6:0] == rv_isa_pkg::OP && w[30]) ? a - b : a + b;
          3'b001: val = a << b[4:0];
          3'b010: val = ($signed(a) < $signed(b)) ? 1 : 0;
          3'b011: val = (a < b) ? 1 : 0;
          3'b100: val = a ^ b;
          3'b101: begin
            if (w[30])
              val = $signed(a) >>> b[4:0];
            else
              val = a >> b[4:0];
          end
          3'b110: val = a | b;
          default: val = a & b;
        endcase
      end
      rv_isa_pkg::LUI: begin
        wr = 1'b1;
        val = imm_value(w, rv_pipe_pkg::IMM_U);
      end
      rv_isa_pkg::AUIPC: begin
        wr = 1'b1;
        val = pc + imm_value(w, rv_pipe_pkg::IMM_U);
      end
      rv_isa_pkg::JAL: begin
        wr = 1'b1;
        val = pc + 4;
        redir = 1'b1;
        next_pc = pc + imm_value(w, rv_pipe_pkg::IMM_J);
      end
      rv_isa_pkg::JALR: begin
        wr = 1'b1;
        val = pc + 4;
        redir = 1'b1;
        next_pc = (a + imm_value(w, rv_pipe_pkg::IMM_I)) & ~XLEN'(1);
      end
      rv_isa_pkg::BRANCH: begin
        case (f3)
          3'b000: taken = (a == b);
          3'b001: taken = (a != b);
          3'b100: taken = ($signed(a) < $signed(b));
          3'b101: taken = ($signed(a) >= $signed(b));
          3'b110: taken = (a < b);
          default: taken = (a >= b);
        endcase
        redir = taken;
        if (taken)
          next_pc = pc + imm_value(w, rv_pipe_pkg::IMM_B);
      end
      default: trap = 1'b1;
    endcase
    if (rd == 5'd0)
      wr = 1'b0;           // x0 is never an expected write
    if (wr)
      iss_regs[rd] = val;
  endfunction

  task automatic run_reference();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] val;
    logic [4:0]      rd;
    logic            wr;
    logic            redir;
    logic            trap;
    for (int i = 0; i < 32; i++) iss_regs[i] = '0;
    pc = `RESET_PC;
    while (pc >= `RESET_PC && ((pc - `RESET_PC) >> 2) < prog_len) begin
      iss_step(prog[(pc - `RESET_PC) >> 2], pc, next_pc, wr, rd, val, redir, trap);
      if (wr) begin
        exp_rd.push_back(rd);
        exp_data.push_back(val);
      end
      if (redir) exp_redirect.push_back(next_pc);
      if (trap) exp_trap.push_back(pc);
      pc = next_pc;
    end
  endtask

  task automatic check_wb(input logic [4:0] rd, input logic [XLEN-1:0] data);
    if (exp_rd.size() == 0) begin
      $display("Unexpected register write to x%0d at %0t", rd, $time);
      other_count++;
    end else begin
      if (rd !== exp_rd[0] || data !== exp_data[0]) begin
        $display("Mismatch at %0t: write x%0d = %h, expected x%0d = %h",
                 $time, rd, data, exp_rd[0], exp_data[0]);
        mismatch_count++;
      end
      void'(exp_rd.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  task automatic check_redirect(input logic [XLEN-1:0] pc);
    if (exp_redirect.size() == 0) begin
      $display("Unexpected redirect to %h at %0t", pc, $time);
      other_count++;
    end else if (pc !== exp_redirect.pop_front()) begin
      $display("Mismatch at %0t: redirect to %h is wrong", $time, pc);
      mismatch_count++;
    end
  endtask

  task automatic check_trap(input logic [XLEN-1:0] pc);
    if (exp_trap.size() == 0) begin
      $display("Unexpected trap at PC %h at %0t", pc, $time);
      other_count++;
    end else if (pc !== exp_trap.pop_front()) begin
      $display("Mismatch at %0t: trap PC %h is wrong", $time, pc);
      mismatch_count++;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (reset_n) begin
      if (wb_valid) check_wb(wb_rd, wb_data);
      if (redirect_valid) check_redirect(redirect_pc);
      if (trap_valid) check_trap(trap_pc);
    end
  end

  always @(posedge clk) begin
    if (reset_n) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout after %0d cycles, fetch never completed", cycles);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  initial begin
    int idx;
    instr = 32'd0;
    instr_pc = '0;
    instr_valid = 1'b0;
    reset_n = 1'b0;
    fetch_pc = `RESET_PC;
    build_program();
    run_reference();
    cycle_limit = 4 * prog_len + 100;
    repeat (16) @(negedge clk);
    reset_n = 1'b1;
    while (!fetch_done) begin
      @(negedge clk);
      idx = (fetch_pc - `RESET_PC) >> 2;
      if (fetch_pc >= `RESET_PC && idx < prog_len) begin
        instr = prog[idx];
        instr_pc = fetch_pc;
        instr_valid = 1'b1;
      end else begin
        instr = 32'd0;
        instr_valid = 1'b0;
      end
      if (redirect_valid)
        fetch_pc = redirect_pc;     // Word presented now is the wrong path
      else if (instr_valid)
        fetch_pc = fetch_pc + 4;
      else
        fetch_done = 1'b1;
    end
    repeat (4) @(negedge clk);      // Pipeline drain
    if (exp_rd.size() != 0 || exp_redirect.size() != 0 || exp_trap.size() != 0) begin
      $display("Program ended with %0d writes, %0d redirects and %0d traps never seen",
               exp_rd.size(), exp_redirect.size(), exp_trap.size());
      other_count++;
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_decoder.sv
rv_regfile.sv
idex_register.sv
rv_execute.sv
rv_id_ex_core.sv
rv_id_ex_properties.sv
tb_rv_id_ex_core.sv
